// File: flist.f
src/fp_add_pkg.sv
src/fp_unpack.sv
src/fp_align_add.sv
src/fp_normalize.sv
src/fp_round_pack.sv
src/fp_adder.sv
verif/fp_adder_properties.sv
verif/fp_adder_tb.sv

// File: Makefile
TOP = fp_adder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > run.log 2>&1 || echo "=== FAIL ===" >> run.log
	@cat run.log
	@if grep -q "=== FAIL ===" run.log; then exit 1; fi

clean:
	rm -rf obj_dir run.log

// File: verif/fp_adder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fp_adder_tb;
  import fp_add_pkg::*;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  fp32_t       a;
  fp32_t       b;
  round_mode_e rmode;
  logic        out_valid;
  logic        out_ready;
  fp32_t       result;
  logic        overflow;
  logic        underflow;

  int   seed = 32'h0517594d;
  int   cycle;
  int   num_vec;
  int   value_errors;
  int   other_errors;
  int   latency;
  bit   timed;
  logic pressure;

  // Stimulus vectors
  fp32_t      vec_a[$];
  fp32_t      vec_b[$];
  logic [2:0] vec_m[$];

  // Scoreboard, one entry per accepted input
  fp32_t      exp_word_q[$];
  logic [1:0] exp_flag_q[$];
  int         acc_cycle_q[$];
  bit         timed_q[$];

  fp_adder UUT (
    .clk(clk),
    .reset(reset),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .a(a),
    .b(b),
    .rmode(rmode),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .result(result),
    .overflow(overflow),
    .underflow(underflow)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // Exact sum in integer units of the smallest subnormal, then IEEE rounding
  function automatic void fp_add_ref(input fp32_t x, input fp32_t y, input logic [2:0] mode,
                                     output fp32_t word, output logic [1:0] flags);
    logic [287:0] mx;
    logic [287:0] my;
    logic [287:0] m;
    logic [287:0] rem;
    logic [287:0] half;
    logic [24:0]  keep;
    logic [2:0]   md;
    logic         nan_x;
    logic         nan_y;
    logic         inf_x;
    logic         inf_y;
    logic         s;
    logic         inc;
    logic         inexact;
    int           p;
    int           sh;
    int           e;
    md = (mode > 3'd4) ? 3'd0 : mode;
    flags = 2'b00;
    inexact = 1'b0;
    nan_x = (x[30:23] == 8'hff) && (x[22:0] != '0);
    nan_y = (y[30:23] == 8'hff) && (y[22:0] != '0);
    inf_x = (x[30:23] == 8'hff) && (x[22:0] == '0);
    inf_y = (y[30:23] == 8'hff) && (y[22:0] == '0);
    if (nan_x || nan_y || (inf_x && inf_y && (x[31] != y[31]))) begin
      word = 32'h7fc0_0000;
    end else if (inf_x) begin
      word = x;
    end else if (inf_y) begin
      word = y;
    end else begin
      mx = 288'({x[30:23] != 8'd0, x[22:0]});
      my = 288'({y[30:23] != 8'd0, y[22:0]});
      if (x[30:23] > 8'd1) mx = mx << (x[30:23] - 8'd1);
      if (y[30:23] > 8'd1) my = my << (y[30:23] - 8'd1);
      if (x[31] == y[31]) begin
        m = mx + my;
        s = x[31];
      end else if (mx >= my) begin
        m = mx - my;
        s = x[31];
      end else begin
        m = my - mx;
        s = y[31];
      end
      // Exact zero from unlike signs is negative only when rounding down
      if (m == '0 && x[31] != y[31]) s = (md == 3'd2);
      p = -1;
      for (int i = 0; i < 288; i++) begin
        if (m[i]) p = i;
      end
      if (p < 24) begin
        // Fits the subnormal or lowest normal range as is
        word = {s, m[30:0]};
      end else begin
        sh = p - 23;
        keep = 25'(m >> sh);
        rem = m & ((288'd1 << sh) - 288'd1);
        half = 288'd1 << (sh - 1);
        inexact = (rem != '0);
        case (md)
          3'd1:    inc = 1'b0;
          3'd2:    inc = s && inexact;
          3'd3:    inc = !s && inexact;
          3'd4:    inc = (rem >= half);
          default: inc = (rem > half) || ((rem == half) && keep[0]);
        endcase
        keep = keep + 25'(inc);
        e = sh + 1;
        if (keep[24]) begin
          keep = keep >> 1;
          e = e + 1;
        end
        if (e >= 255) begin
          flags[1] = 1'b1;
          if (md == 3'd1 || (md == 3'd2 && !s) || (md == 3'd3 && s)) begin
            word = {s, 8'hfe, 23'h7f_ffff};
          end else begin
            word = {s, 8'hff, 23'h0};
          end
        end else begin
          word = {s, e[7:0], keep[22:0]};
        end
      end
      flags[0] = (word[30:23] == 8'd0) && inexact;
    end
  endfunction

  task automatic check_result(input fp32_t expected, input fp32_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Error: result expected %h got %h", expected, actual);
    end
  endtask

  task automatic check_flags(input logic [1:0] expected, input logic [1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("Error: {overflow,underflow} expected %h got %h", expected, actual);
    end
  endtask

  task automatic add_vec(input fp32_t x, input fp32_t y, input logic [2:0] mode);
    vec_a.push_back(x);
    vec_b.push_back(y);
    vec_m.push_back(mode);
  endtask

  task automatic add_all_modes(input fp32_t x, input fp32_t y);
    for (int m = 0; m < 5; m++) begin
      add_vec(x, y, 3'(m));
    end
  endtask

  task automatic build_directed();
    // Halfway cases where rne and rmm part ways
    add_all_modes(32'h3f80_0000, 32'h3380_0000);
    add_all_modes(32'h3f80_0001, 32'h3380_0000);
    add_all_modes(32'hbf80_0001, 32'hb380_0000);
    add_all_modes(32'h4049_0fdb, 32'hbf80_0000);
    // Cancellation and near cancellation
    add_all_modes(32'h4049_0fdb, 32'hc049_0fdb);
    add_all_modes(32'h3f80_0001, 32'hbf80_0000);
    add_all_modes(32'h4000_0000, 32'hbfff_ffff);
    // Subnormals
    add_all_modes(32'h0000_0001, 32'h0000_0001);
    add_all_modes(32'h007f_ffff, 32'h0000_0001);
    add_all_modes(32'h0080_0000, 32'h8000_0001);
    add_all_modes(32'h3f80_0000, 32'h0000_0001);
    // Near the largest finite value
    add_all_modes(32'h7f7f_ffff, 32'h7f7f_ffff);
    add_all_modes(32'h7f7f_ffff, 32'h7300_0000);
    add_all_modes(32'hff7f_ffff, 32'hff7f_ffff);
    // Specials and signed zeros
    add_all_modes(32'h7fc0_0000, 32'h3f80_0000);
    add_all_modes(32'h3f80_0000, 32'h7f80_0001);
    add_all_modes(32'h7f80_0000, 32'hff80_0000);
    add_all_modes(32'hff80_0000, 32'h7f7f_ffff);
    add_all_modes(32'h7f80_0000, 32'h7f80_0000);
    add_all_modes(32'h8000_0000, 32'h0000_0000);
    add_all_modes(32'h8000_0000, 32'h8000_0000);
  endtask

  task automatic add_random(input int count);
    int    r;
    int    e1;
    int    e2;
    fp32_t x;
    fp32_t y;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      x = $random(seed);
      y = $random(seed);
      case (r[3:1])
        3'd4: begin
          x[30:23] = 8'd0;
          y[30:23] = 8'd0;
        end
        3'd5: begin
          x[30:23] = {5'd0, r[6:4]};
          y[30:23] = 8'd0;
        end
        3'd6: begin
          x[30:23] = 8'hfe;
          y[30:23] = 8'hfe - {4'd0, r[7:4]};
        end
        3'd7: begin
          x[30:23] = 8'hff;
          if (r[5]) x[22:0] = '0;
        end
        default: begin
          // Normals with nearby exponents
          e1 = 1 + (x[30:23] % 254);
          e2 = e1 + int'(r[8:4]) - 15;
          if (e2 < 1) e2 = 1;
          if (e2 > 254) e2 = 254;
          x[30:23] = e1[7:0];
          y[30:23] = e2[7:0];
        end
      endcase
      add_vec(x, y, r[18:16]);
    end
  endtask

  task automatic expect_item(input fp32_t x, input fp32_t y, input logic [2:0] mode);
    fp32_t      w;
    logic [1:0] f;
    fp_add_ref(x, y, mode, w, f);
    exp_word_q.push_back(w);
    exp_flag_q.push_back(f);
    acc_cycle_q.push_back(cycle);
    timed_q.push_back(!pressure);
  endtask

  task automatic run_vectors(input int first, input int last, input logic stall);
    int idx;
    int r;
    idx = first;
    pressure <= stall;
    while (idx <= last) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        expect_item(a, b, rmode);
        idx++;
      end
      r = $random(seed);
      // Output stalls only while back-pressure is on
      out_ready <= !stall || r[2];
      // A pending offer is held until taken
      if (!in_valid || in_ready) begin
        if (idx <= last && (!stall || r[1:0] != 2'b00)) begin
          in_valid <= 1'b1;
          a <= vec_a[idx];
          b <= vec_b[idx];
          rmode <= round_mode_e'(vec_m[idx]);
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  endtask

  task automatic drain(input int max_cycles);
    int n;
    int r;
    n = 0;
    while (exp_word_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      r = $random(seed);
      out_ready <= !pressure || r[2];
      n++;
    end
  endtask

  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (exp_word_q.size() == 0) begin
        other_errors++;
        $display("Result %h came out with no input waiting for it", result);
      end else begin
        check_result(exp_word_q.pop_front(), result);
        check_flags(exp_flag_q.pop_front(), {overflow, underflow});
        latency = cycle - acc_cycle_q.pop_front();
        timed = timed_q.pop_front();
        if (timed && latency != PIPE_DEPTH) begin
          other_errors++;
          $display("Result came %0d cycles after its input, not %0d", latency, PIPE_DEPTH);
        end
      end
    end
  end

  initial begin : watchdog
    wait (num_vec > 0);
    repeat (num_vec * 4 + PIPE_DEPTH + 50) @(posedge clk);
    $display("Timeout: the run did not complete in time, %0d results pending",
             exp_word_q.size());
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    int ndir;
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    rmode = rne;
    out_ready = 1'b1;
    pressure = 1'b0;
    build_directed();
    ndir = vec_a.size();
    add_random(400);
    num_vec = vec_a.size();
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // Directed set with a free-flowing output
    run_vectors(0, ndir - 1, 1'b0);
    drain(50);
    // Random set with input gaps and output back-pressure
    run_vectors(ndir, num_vec - 1, 1'b1);
    drain(200);
    repeat (5) @(posedge clk);
    if (exp_word_q.size() != 0) begin
      other_errors++;
      $display("%0d expected results never came out", exp_word_q.size());
    end
    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/fp_adder_properties.sv
`timescale 1ns/1ps
`default_nettype none

module fp_adder_properties (
  input logic              clk,
  input logic              reset,
  input logic              in_valid,
  input logic              in_ready,
  input logic              out_valid,
  input logic              out_ready,
  input fp_add_pkg::fp32_t result,
  input logic              overflow,
  input logic              underflow
);
  import fp_add_pkg::*;

  // Recent out_ready values, newest in bit 0
  logic [PIPE_DEPTH-2:0] ready_hist;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready_hist <= '0;
    end else begin
      ready_hist <= {ready_hist[PIPE_DEPTH-3:0], out_ready};
    end
  end

  out_idle_in_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high during or just after reset");

  out_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(result) && $stable(overflow)
                                && $stable(underflow))
    else $error("Output changed while stalled");

  // Free-flowing output gives a fixed latency
  fixed_latency: assert property (@(posedge clk) disable iff (reset)
    $past(in_valid && in_ready, PIPE_DEPTH) && (&ready_hist) |-> out_valid)
    else $error("out_valid missing after the pipeline latency");

endmodule

bind fp_adder fp_adder_properties u_properties (
  .clk(clk),
  .reset(reset),
  .in_valid(in_valid),
  .in_ready(in_ready),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .result(result),
  .overflow(overflow),
  .underflow(underflow)
);

`default_nettype wire

// File: src/fp_adder.sv
`timescale 1ns/1ps
`default_nettype none

module fp_adder (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  output logic                     in_ready,
  input  fp_add_pkg::fp32_t        a,
  input  fp_add_pkg::fp32_t        b,
  input  fp_add_pkg::round_mode_e  rmode,
  output logic                     out_valid,
  input  logic                     out_ready,
  output fp_add_pkg::fp32_t        result,
  output logic                     overflow,
  output logic                     underflow
);
  import fp_add_pkg::*;

  // Unpacked operands
  logic             sign_a;
  logic             sign_b;
  logic [EXP_W-1:0] exp_a;
  logic [EXP_W-1:0] exp_b;
  logic [SIG_W-1:0] sig_a;
  logic [SIG_W-1:0] sig_b;
  logic             is_nan_a;
  logic             is_nan_b;
  logic             is_inf_a;
  logic             is_inf_b;
  logic             is_zero_a;
  logic             is_zero_b;

  // Aligned sum stage
  logic             sum_valid;
  logic             sum_ready;
  logic             sum_sign;
  logic [EXP_W-1:0] sum_exp;
  logic [EXT_W:0]   sum_mag;
  round_mode_e      sum_mode;
  logic             sum_special;
  fp32_t            sum_special_word;

  // Normalized stage
  logic             norm_valid;
  logic             norm_ready;
  logic             norm_sign;
  logic [EXP_W-1:0] norm_exp;
  logic [EXT_W-1:0] norm_sig;
  round_mode_e      norm_mode;
  logic             norm_special;
  fp32_t            norm_special_word;
  logic             norm_zero;

  fp_unpack u_unpack (.*);

  fp_align_add u_align_add (.*);

  fp_normalize u_normalize (.*);

  fp_round_pack u_round_pack (.*);

endmodule

`default_nettype wire

// File: src/fp_round_pack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_round_pack (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          norm_valid,
  output logic                          norm_ready,
  input  logic                          norm_sign,
  input  logic [fp_add_pkg::EXP_W-1:0]  norm_exp,
  input  logic [fp_add_pkg::EXT_W-1:0]  norm_sig,
  input  fp_add_pkg::round_mode_e       norm_mode,
  input  logic                          norm_special,
  input  fp_add_pkg::fp32_t             norm_special_word,
  input  logic                          norm_zero,
  output logic                          out_valid,
  input  logic                          out_ready,
  output fp_add_pkg::fp32_t             result,
  output logic                          overflow,
  output logic                          underflow
);
  import fp_add_pkg::*;

  logic             guard;
  logic             rest;
  logic             inexact;
  logic             inc;
  logic             to_inf;
  logic [SIG_W:0]   rounded;
  logic [EXP_W:0]   exp_r;
  logic [MAN_W-1:0] frac_r;
  logic             ovf;
  fp32_t            word;
  logic             load;

  assign guard   = norm_sig[2];
  assign rest    = |norm_sig[1:0];
  assign inexact = guard || rest;

  always_comb begin
    case (norm_mode)
      rtz:     inc = 1'b0;
      rdn:     inc = norm_sign && inexact;
      rup:     inc = !norm_sign && inexact;
      rmm:     inc = guard;
      // Nearest even, also for the unused codes
      default: inc = guard && (rest || norm_sig[3]);
    endcase
  end

  // Direction taken once the exponent saturates
  always_comb begin
    case (norm_mode)
      rtz:     to_inf = 1'b0;
      rdn:     to_inf = norm_sign;
      rup:     to_inf = !norm_sign;
      default: to_inf = 1'b1;
    endcase
  end

  assign rounded = {1'b0, norm_sig[EXT_W-1:3]} + {{SIG_W{1'b0}}, inc};

  // Carry past the significand, or a subnormal rounding up into the normal range
  assign exp_r = {1'b0, norm_exp} + {{EXP_W{1'b0}}, rounded[SIG_W]}
               + {{EXP_W{1'b0}}, (norm_exp == '0) && rounded[SIG_W-1]};
  assign frac_r = rounded[SIG_W] ? rounded[MAN_W:1] : rounded[MAN_W-1:0];
  assign ovf    = exp_r >= {1'b0, EXP_MAX};

  always_comb begin
    if (norm_special) begin
      word = norm_special_word;
    end else if (ovf) begin
      word = to_inf ? {norm_sign, EXP_MAX, {MAN_W{1'b0}}}
                    : {norm_sign, EXP_MAX - 8'd1, {MAN_W{1'b1}}};
    end else begin
      word = {norm_sign, exp_r[EXP_W-1:0], frac_r};
    end
  end

  assign norm_ready = !out_valid || out_ready;
  assign load       = norm_valid && norm_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result    <= word;
      overflow  <= !norm_special && ovf;
      // Tiny after rounding and something was lost
      underflow <= !norm_special && !norm_zero && (exp_r == '0) && inexact;
    end
  end

endmodule

`default_nettype wire

// File: src/fp_normalize.sv
`timescale 1ns/1ps
`default_nettype none

module fp_normalize (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sum_valid,
  output logic                          sum_ready,
  input  logic                          sum_sign,
  input  logic [fp_add_pkg::EXP_W-1:0]  sum_exp,
  input  logic [fp_add_pkg::EXT_W:0]    sum_mag,
  input  fp_add_pkg::round_mode_e       sum_mode,
  input  logic                          sum_special,
  input  fp_add_pkg::fp32_t             sum_special_word,
  output logic                          norm_valid,
  input  logic                          norm_ready,
  output logic                          norm_sign,
  output logic [fp_add_pkg::EXP_W-1:0]  norm_exp,
  output logic [fp_add_pkg::EXT_W-1:0]  norm_sig,
  output fp_add_pkg::round_mode_e       norm_mode,
  output logic                          norm_special,
  output fp_add_pkg::fp32_t             norm_special_word,
  output logic                          norm_zero
);
  import fp_add_pkg::*;

  logic [4:0]       lzc;
  logic [EXP_W-1:0] room;
  logic [EXP_W-1:0] shamt;
  logic [EXT_W-1:0] shifted;
  logic [EXT_W-1:0] sig_n;
  logic [EXP_W-1:0] exp_n;
  logic             load;

  function automatic logic [4:0] lead_zeros(input logic [EXT_W-1:0] v);
    logic [4:0] n;
    logic       found;
    n = 5'd0;
    found = 1'b0;
    for (int i = EXT_W - 1; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 5'd1;
      end
    end
    return n;
  endfunction

  assign lzc = lead_zeros(sum_mag[EXT_W-1:0]);

  // Left shift may not take the exponent below 1
  assign room    = sum_exp - EXP_W'(1);
  assign shamt   = ({3'b000, lzc} > room) ? room : {3'b000, lzc};
  assign shifted = sum_mag[EXT_W-1:0] << shamt;

  always_comb begin
    if (sum_mag[EXT_W]) begin
      // Carry out, the dropped bit joins sticky
      sig_n = {sum_mag[EXT_W:2], sum_mag[1] | sum_mag[0]};
      exp_n = sum_exp + EXP_W'(1);
    end else begin
      sig_n = shifted;
      // Still no hidden bit, so the result is subnormal
      exp_n = shifted[EXT_W-1] ? sum_exp - shamt : '0;
    end
  end

  assign sum_ready = !norm_valid || norm_ready;
  assign load      = sum_valid && sum_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      norm_valid <= 1'b0;
    end else if (load) begin
      norm_valid <= 1'b1;
    end else if (norm_ready) begin
      norm_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      norm_sign         <= sum_sign;
      norm_exp          <= exp_n;
      norm_sig          <= sig_n;
      norm_mode         <= sum_mode;
      norm_special      <= sum_special;
      norm_special_word <= sum_special_word;
      norm_zero         <= (sum_mag == '0);
    end
  end

endmodule

`default_nettype wire

// File: src/fp_align_add.sv
`timescale 1ns/1ps
`default_nettype none

module fp_align_add (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic                          sign_a,
  input  logic                          sign_b,
  input  logic [fp_add_pkg::EXP_W-1:0]  exp_a,
  input  logic [fp_add_pkg::EXP_W-1:0]  exp_b,
  input  logic [fp_add_pkg::SIG_W-1:0]  sig_a,
  input  logic [fp_add_pkg::SIG_W-1:0]  sig_b,
  input  logic                          is_nan_a,
  input  logic                          is_nan_b,
  input  logic                          is_inf_a,
  input  logic                          is_inf_b,
  input  logic                          is_zero_a,
  input  logic                          is_zero_b,
  input  fp_add_pkg::round_mode_e       rmode,
  output logic                          sum_valid,
  input  logic                          sum_ready,
  output logic                          sum_sign,
  output logic [fp_add_pkg::EXP_W-1:0]  sum_exp,
  output logic [fp_add_pkg::EXT_W:0]    sum_mag,
  output fp_add_pkg::round_mode_e       sum_mode,
  output logic                          sum_special,
  output fp_add_pkg::fp32_t             sum_special_word
);
  import fp_add_pkg::*;

  logic             a_big;
  logic             eff_sub;
  logic [EXP_W-1:0] exp_diff;
  logic [SIG_W-1:0] big_sig;
  logic [EXT_W-1:0] small_ext;
  logic [EXT_W-1:0] shifted;
  logic             sticky;
  logic [EXT_W-1:0] aligned;
  logic [EXT_W:0]   mag;
  logic             res_sign;
  logic             is_nan;
  logic             load;

  // A zero operand never wins the ordering
  assign a_big   = is_zero_b || (!is_zero_a && ({exp_a, sig_a} >= {exp_b, sig_b}));
  assign eff_sub = sign_a ^ sign_b;
  assign exp_diff = a_big ? exp_a - exp_b : exp_b - exp_a;
  assign big_sig  = a_big ? sig_a : sig_b;
  assign small_ext = {(a_big ? sig_b : sig_a), 3'b000};

  // Smaller operand shifted right, lost bits folded into sticky
  assign shifted = small_ext >> exp_diff;
  assign sticky  = |(small_ext & ~({EXT_W{1'b1}} << exp_diff));
  assign aligned = {shifted[EXT_W-1:1], shifted[0] | sticky};

  assign mag = eff_sub ? {1'b0, big_sig, 3'b000} - {1'b0, aligned}
                       : {1'b0, big_sig, 3'b000} + {1'b0, aligned};

  always_comb begin
    if (mag == '0) begin
      // Exact cancellation gives -0 only when rounding downward
      res_sign = eff_sub ? (rmode == rdn) : sign_a;
    end else begin
      res_sign = a_big ? sign_a : sign_b;
    end
  end

  assign is_nan = is_nan_a || is_nan_b || (is_inf_a && is_inf_b && eff_sub);

  assign in_ready = !sum_valid || sum_ready;
  assign load     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else if (load) begin
      sum_valid <= 1'b1;
    end else if (sum_ready) begin
      sum_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      sum_sign    <= res_sign;
      sum_exp     <= a_big ? exp_a : exp_b;
      sum_mag     <= mag;
      sum_mode    <= rmode;
      sum_special <= is_nan || is_inf_a || is_inf_b;
      // Infinity keeps its own sign, equal-sign pairs agree anyway
      sum_special_word <= is_nan ? QNAN
                                 : {is_inf_a ? sign_a : sign_b, EXP_MAX, {MAN_W{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: src/fp_unpack.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
  input  fp_add_pkg::fp32_t                a,
  input  fp_add_pkg::fp32_t                b,
  output logic                             sign_a,
  output logic                             sign_b,
  output logic [fp_add_pkg::EXP_W-1:0]     exp_a,
  output logic [fp_add_pkg::EXP_W-1:0]     exp_b,
  output logic [fp_add_pkg::SIG_W-1:0]     sig_a,
  output logic [fp_add_pkg::SIG_W-1:0]     sig_b,
  output logic                             is_nan_a,
  output logic                             is_nan_b,
  output logic                             is_inf_a,
  output logic                             is_inf_b,
  output logic                             is_zero_a,
  output logic                             is_zero_b
);
  import fp_add_pkg::*;

  logic [EXP_W-1:0] raw_exp_a;
  logic [EXP_W-1:0] raw_exp_b;
  logic [MAN_W-1:0] frac_a;
  logic [MAN_W-1:0] frac_b;

  assign sign_a    = a[31];
  assign sign_b    = b[31];
  assign raw_exp_a = a[30:23];
  assign raw_exp_b = b[30:23];
  assign frac_a    = a[MAN_W-1:0];
  assign frac_b    = b[MAN_W-1:0];

  // Subnormals and zeros sit at the scale of exponent 1
  assign exp_a = (raw_exp_a == '0) ? EXP_W'(1) : raw_exp_a;
  assign exp_b = (raw_exp_b == '0) ? EXP_W'(1) : raw_exp_b;

  // Hidden bit only for nonzero exponent
  assign sig_a = {raw_exp_a != '0, frac_a};
  assign sig_b = {raw_exp_b != '0, frac_b};

  assign is_nan_a  = (raw_exp_a == EXP_MAX) && (frac_a != '0);
  assign is_nan_b  = (raw_exp_b == EXP_MAX) && (frac_b != '0);
  assign is_inf_a  = (raw_exp_a == EXP_MAX) && (frac_a == '0);
  assign is_inf_b  = (raw_exp_b == EXP_MAX) && (frac_b == '0);
  assign is_zero_a = (raw_exp_a == '0) && (frac_a == '0);
  assign is_zero_b = (raw_exp_b == '0) && (frac_b == '0);

endmodule

`default_nettype wire

// File: src/fp_add_pkg.sv
`default_nettype none

package fp_add_pkg;

  // Single-precision word
  typedef logic [31:0] fp32_t;

  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } round_mode_e;

  localparam int EXP_W = 8;
  localparam int MAN_W = 23;
  // Fraction plus hidden bit
  localparam int SIG_W = MAN_W + 1;
  // Significand followed by guard, round and sticky
  localparam int EXT_W = SIG_W + 3;

  localparam logic [EXP_W-1:0] EXP_MAX = 8'd255;
  localparam fp32_t QNAN = 32'h7fc0_0000;

  // Register stages from input to output
  localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire
